// File: source/csr_pkg.sv
package csr_pkg;

    // Data, pc and CSR width
    localparam int XLEN = 32;

    // CSR commands from the decode stage
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only User and Machine exist
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_e;

    typedef enum logic [1:0] {
        TRAP_NONE   = 2'd0,
        TRAP_ENTER  = 2'd1,
        TRAP_RETURN = 2'd2
    } trap_kind_e;

    // Machine trap setup and handling
    localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] ADDR_MISA     = 12'h301;
    localparam logic [11:0] ADDR_MIE      = 12'h304;
    localparam logic [11:0] ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] ADDR_MEPC     = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] ADDR_MIP      = 12'h344;
    // Counters, all fed from outside
    localparam logic [11:0] ADDR_MCYCLE   = 12'hb00;
    localparam logic [11:0] ADDR_MCYCLEH  = 12'hb80;
    localparam logic [11:0] ADDR_CYCLE    = 12'hc00;
    localparam logic [11:0] ADDR_TIME     = 12'hc01;
    localparam logic [11:0] ADDR_CYCLEH   = 12'hc80;
    localparam logic [11:0] ADDR_TIMEH    = 12'hc81;

    // MXL = 32 bit, extensions A (bit 0), I (bit 8), M (bit 12)
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1101;

    localparam logic [XLEN-1:0] CAUSE_ECALL_U     = 32'd8;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M     = 32'd11;
    localparam logic [XLEN-1:0] CAUSE_M_TIMER_IRQ = 32'h8000_0007;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    // Same position in mie and mip
    localparam int MTIP_MTIE_BIT    = 7;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        csr_cmd_e        cmd;
        logic [XLEN-1:0] op1;
        logic [11:0]     addr;
        logic            mem_write;
    } csr_req_t;

    typedef struct packed {
        logic            en;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
    } csr_write_t;

    typedef struct packed {
        logic            take;
        trap_kind_e      kind;
        logic            to_user;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] epc;
        priv_mode_e      prev_mode;
    } trap_update_t;

    typedef struct packed {
        logic       mie;
        logic       mpie;
        logic [1:0] mpp;
    } mstatus_view_t;

endpackage

// File: source/csr_access_decode.sv
`timescale 1ns/1ps

module csr_access_decode (
    input  logic                     csr_valid,
    input  csr_pkg::csr_req_t        req,
    input  csr_pkg::priv_mode_e      mode,
    input  logic [csr_pkg::XLEN-1:0] cur_rdata,
    output logic                     rd_ok,
    output csr_pkg::csr_write_t      wr
);

    logic                     access_ok;
    logic                     read_only;
    logic                     write_ok;
    logic                     is_write_cmd;
    logic [csr_pkg::XLEN-1:0] wdata;

    // Address bits 9:8 hold the lowest privilege allowed
    assign access_ok = req.addr[9:8] <= mode;

    // Top two bits both set marks a read-only CSR
    assign read_only = &req.addr[11:10];
    assign write_ok  = access_ok & ~read_only;

    assign is_write_cmd = (req.cmd == csr_pkg::CSR_W) ||
                          (req.cmd == csr_pkg::CSR_S) ||
                          (req.cmd == csr_pkg::CSR_C);

    // New value from the current CSR contents
    always_comb begin
        case (req.cmd)
            csr_pkg::CSR_W: wdata = req.op1;
            csr_pkg::CSR_S: wdata = cur_rdata | req.op1;
            csr_pkg::CSR_C: wdata = cur_rdata & ~req.op1;
            default:        wdata = '0;
        endcase
    end

    // Read permission only, the register block samples it on valid
    assign rd_ok = access_ok;

    assign wr.en   = csr_valid & is_write_cmd & write_ok;
    assign wr.addr = req.addr;
    assign wr.data = wdata;

    // Any write must also be a permitted read of the same CSR
    always_comb begin
        if (wr.en) begin
            assert (rd_ok)
            else $error("csr write without read permission, addr %h", req.addr);
        end
    end

endmodule

// File: source/csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          csr_valid,
    input  logic [11:0]                   rd_addr,
    input  logic                          rd_ok,
    input  csr_pkg::csr_write_t           wr,
    input  csr_pkg::trap_update_t         trap_upd,
    input  logic [63:0]                   cycle_count,
    input  logic [63:0]                   mtime,
    input  logic [63:0]                   mtimecmp,
    output logic [csr_pkg::XLEN-1:0]      cur_rdata,
    output logic [csr_pkg::XLEN-1:0]      rdata,
    output csr_pkg::mstatus_view_t        mstat,
    output logic [csr_pkg::XLEN-1:0]      mtvec,
    output logic [csr_pkg::XLEN-1:0]      mepc,
    output logic                          mtie,
    output logic                          mtip
);

    logic [csr_pkg::XLEN-1:0] mscratch;
    logic [csr_pkg::XLEN-1:0] mcause;
    logic [csr_pkg::XLEN-1:0] mstatus_word;
    logic                     trap_enter;
    logic                     trap_return;
    logic                     irq_taken;

    assign trap_enter  = trap_upd.take && (trap_upd.kind == csr_pkg::TRAP_ENTER);
    assign trap_return = trap_upd.take && (trap_upd.kind == csr_pkg::TRAP_RETURN);
    // Timer interrupt is the only asynchronous cause
    assign irq_taken   = trap_enter && (trap_upd.cause == csr_pkg::CAUSE_M_TIMER_IRQ);

    // mstatus with only MIE, MPIE and MPP implemented
    always_comb begin
        mstatus_word = '0;
        mstatus_word[csr_pkg::MSTATUS_MIE_BIT]          = mstat.mie;
        mstatus_word[csr_pkg::MSTATUS_MPIE_BIT]         = mstat.mpie;
        mstatus_word[csr_pkg::MSTATUS_MPP_LSB +: 2]     = mstat.mpp;
    end

    // Combinational view of the addressed CSR
    always_comb begin
        cur_rdata = '0;
        case (rd_addr)
            csr_pkg::ADDR_MSTATUS:  cur_rdata = mstatus_word;
            csr_pkg::ADDR_MISA:     cur_rdata = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MIE:      cur_rdata[csr_pkg::MTIP_MTIE_BIT] = mtie;
            csr_pkg::ADDR_MTVEC:    cur_rdata = mtvec;
            csr_pkg::ADDR_MSCRATCH: cur_rdata = mscratch;
            csr_pkg::ADDR_MEPC:     cur_rdata = mepc;
            csr_pkg::ADDR_MCAUSE:   cur_rdata = mcause;
            csr_pkg::ADDR_MIP:      cur_rdata[csr_pkg::MTIP_MTIE_BIT] = mtip;
            // Counter views, low and high halves
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:    cur_rdata = cycle_count[31:0];
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH:   cur_rdata = cycle_count[63:32];
            csr_pkg::ADDR_TIME:     cur_rdata = mtime[31:0];
            csr_pkg::ADDR_TIMEH:    cur_rdata = mtime[63:32];
            // Unknown addresses read zero
            default:                cur_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata      <= '0;
            mstat.mie  <= 1'b0;
            mstat.mpie <= 1'b0;
            mstat.mpp  <= csr_pkg::PRIV_MACHINE;
            mtie       <= 1'b0;
            mtip       <= 1'b0;
            mtvec      <= '0;
            mscratch   <= '0;
            mepc       <= '0;
            mcause     <= '0;
        end else if (csr_valid) begin
            // Value before this instruction's own write
            rdata <= rd_ok ? cur_rdata : '0;

            // Pending bit follows the timer compare unless an interrupt is taken
            if (!irq_taken) begin
                mtip <= (mtime >= mtimecmp);
            end

            // Trap entry stacks the interrupt enable
            if (trap_enter) begin
                mcause     <= trap_upd.cause;
                mepc       <= trap_upd.epc;
                mstat.mpp  <= trap_upd.prev_mode;
                mstat.mpie <= mstat.mie;
                mstat.mie  <= 1'b0;
            end else if (trap_return) begin
                mstat.mie  <= mstat.mpie;
                mstat.mpie <= 1'b1;
                mstat.mpp  <= csr_pkg::PRIV_USER;
            end

            // Write last so it wins over a return
            if (wr.en) begin
                case (wr.addr)
                    csr_pkg::ADDR_MSTATUS: begin
                        mstat.mie  <= wr.data[csr_pkg::MSTATUS_MIE_BIT];
                        mstat.mpie <= wr.data[csr_pkg::MSTATUS_MPIE_BIT];
                        mstat.mpp  <= wr.data[csr_pkg::MSTATUS_MPP_LSB +: 2];
                    end
                    csr_pkg::ADDR_MIE:      mtie     <= wr.data[csr_pkg::MTIP_MTIE_BIT];
                    csr_pkg::ADDR_MTVEC:    mtvec    <= wr.data;
                    csr_pkg::ADDR_MSCRATCH: mscratch <= wr.data;
                    // mepc stays word aligned
                    csr_pkg::ADDR_MEPC:     mepc     <= {wr.data[csr_pkg::XLEN-1:2], 2'b00};
                    csr_pkg::ADDR_MCAUSE:   mcause   <= wr.data;
                    // mip, misa and the counters ignore writes
                    default: ;
                endcase
            end
        end
    end

    // Trap control and the write path are separate modules, never both at once
    assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_enter && wr.en))
    else $error("trap entry together with csr write, addr %h", wr.addr);

endmodule

// File: source/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          csr_valid,
    input  csr_pkg::csr_req_t             req,
    input  csr_pkg::mstatus_view_t        mstat,
    input  logic [csr_pkg::XLEN-1:0]      mtvec,
    input  logic [csr_pkg::XLEN-1:0]      mepc,
    input  logic                          mtie,
    input  logic                          mtip,
    output csr_pkg::priv_mode_e           mode,
    output logic                          trap_flg,
    output csr_pkg::trap_update_t         trap_upd,
    output logic [csr_pkg::XLEN-1:0]      trap_vector
);

    logic                     irq_pending;
    logic                     take_irq;
    logic                     take_ecall;
    logic                     take_mret;
    logic [csr_pkg::XLEN-1:0] mtvec_base;
    logic [csr_pkg::XLEN-1:0] irq_offset;
    logic [csr_pkg::XLEN-1:0] next_vector;

    // Timer interrupt armed in mip, mie and mstatus
    assign irq_pending = mtip & mtie & mstat.mie;

    // Priority: interrupt, then ECALL, then MRET
    assign take_irq   = csr_valid & ~req.mem_write & irq_pending;
    assign take_ecall = csr_valid & ~take_irq & (req.cmd == csr_pkg::CSR_ECALL);
    assign take_mret  = csr_valid & ~take_irq & ~take_ecall &
                        (req.cmd == csr_pkg::CSR_MRET);

    assign trap_flg = take_irq | take_ecall | take_mret;

    // Vectored mode adds cause times four, 28 for the timer
    assign mtvec_base = {mtvec[csr_pkg::XLEN-1:2], 2'b00};
    assign irq_offset = (mtvec[1:0] == 2'b01) ?
                        {csr_pkg::CAUSE_M_TIMER_IRQ[csr_pkg::XLEN-3:0], 2'b00} : '0;

    always_comb begin
        if (take_irq) begin
            next_vector = mtvec_base + irq_offset;
        end else if (take_ecall) begin
            next_vector = mtvec_base;
        end else begin
            next_vector = mepc;
        end
    end

    // Update applied by the register block on the same edge
    always_comb begin
        trap_upd.take      = trap_flg;
        trap_upd.kind      = csr_pkg::TRAP_NONE;
        if (take_irq || take_ecall) begin
            trap_upd.kind = csr_pkg::TRAP_ENTER;
        end else if (take_mret) begin
            trap_upd.kind = csr_pkg::TRAP_RETURN;
        end
        // Anything other than Machine in MPP returns to User
        trap_upd.to_user   = (mstat.mpp != csr_pkg::PRIV_MACHINE);
        if (take_irq) begin
            trap_upd.cause = csr_pkg::CAUSE_M_TIMER_IRQ;
        end else if (mode == csr_pkg::PRIV_USER) begin
            trap_upd.cause = csr_pkg::CAUSE_ECALL_U;
        end else begin
            trap_upd.cause = csr_pkg::CAUSE_ECALL_M;
        end
        trap_upd.epc       = req.pc;
        trap_upd.prev_mode = mode;
    end

    // Mode and trap vector change only on a taken trap or return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode        <= csr_pkg::PRIV_MACHINE;
            trap_vector <= '0;
        end else if (trap_flg) begin
            trap_vector <= next_vector;
            if (trap_upd.kind == csr_pkg::TRAP_RETURN) begin
                mode <= trap_upd.to_user ? csr_pkg::PRIV_USER : csr_pkg::PRIV_MACHINE;
            end else begin
                mode <= csr_pkg::PRIV_MACHINE;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        trap_flg |-> csr_valid)
    else $error("trap_flg without csr_valid");

endmodule

// File: source/cpu_csr.sv
`timescale 1ns/1ps

module cpu_csr (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          csr_valid,
    input  csr_pkg::csr_req_t             req,
    input  logic [63:0]                   cycle_count,
    input  logic [63:0]                   mtime,
    input  logic [63:0]                   mtimecmp,
    output logic [csr_pkg::XLEN-1:0]      rdata,
    output logic                          trap_flg,
    output logic [csr_pkg::XLEN-1:0]      trap_vector
);

    csr_pkg::priv_mode_e    mode;
    csr_pkg::mstatus_view_t mstat;
    csr_pkg::csr_write_t    wr;
    csr_pkg::trap_update_t  trap_upd;
    logic [csr_pkg::XLEN-1:0] cur_rdata;
    logic [csr_pkg::XLEN-1:0] mtvec;
    logic [csr_pkg::XLEN-1:0] mepc;
    logic                   mtie;
    logic                   mtip;
    logic                   rd_ok;

    // A trapping instruction loses its own CSR write
    wire dec_valid = csr_valid & ~trap_flg;

    csr_access_decode u_access_decode (
        .csr_valid (dec_valid),
        .req       (req),
        .mode      (mode),
        .cur_rdata (cur_rdata),
        .rd_ok     (rd_ok),
        .wr        (wr)
    );

    csr_machine_regs u_machine_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .rd_addr     (req.addr),
        .rd_ok       (rd_ok),
        .wr          (wr),
        .trap_upd    (trap_upd),
        .cycle_count (cycle_count),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .cur_rdata   (cur_rdata),
        .rdata       (rdata),
        .mstat       (mstat),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mtie        (mtie),
        .mtip        (mtip)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .req         (req),
        .mstat       (mstat),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mtie        (mtie),
        .mtip        (mtip),
        .mode        (mode),
        .trap_flg    (trap_flg),
        .trap_upd    (trap_upd),
        .trap_vector (trap_vector)
    );

endmodule

// File: verification/cpu_csr_tb.sv
`timescale 1ns/1ps

module cpu_csr_tb;

    logic                  clk;
    logic                  rst_n;
    logic                  csr_valid;
    csr_pkg::csr_req_t     req;
    logic [63:0]           cycle_count;
    logic [63:0]           mtime;
    logic [63:0]           mtimecmp;
    logic [31:0]           rdata;
    logic                  trap_flg;
    logic [31:0]           trap_vector;

    // Expected results, launched together with the request
    logic [31:0] exp_rdata;
    logic        exp_trap;
    logic [31:0] exp_vec;
    // Same values one cycle later, when the DUT shows them
    logic        valid_q;
    logic [31:0] rdata_q;
    logic        trap_q;
    logic [31:0] vec_q;

    // Reference CSR state
    logic [1:0]  m_mode;
    logic        m_mie;
    logic        m_mpie;
    logic [1:0]  m_mpp;
    logic        m_mtie;
    logic        m_mtip;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    int errors;
    int n_instr;
    int seed;
    int tries;

    cpu_csr u_cpu_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .req         (req),
        .cycle_count (cycle_count),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .rdata       (rdata),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        valid_q <= csr_valid;
        rdata_q <= exp_rdata;
        trap_q  <= csr_valid && exp_trap;
        vec_q   <= exp_vec;
    end

    // Read data one cycle after valid
    rdata_check: assert property (@(posedge clk) disable iff (!rst_n)
        valid_q |-> (rdata == rdata_q))
    else begin
        errors++;
        $display("ERR rdata got %h expected %h", $sampled(rdata), $sampled(rdata_q));
    end

    // Same cycle as valid, and low without valid
    trap_check: assert property (@(posedge clk) disable iff (!rst_n)
        trap_flg == (csr_valid && exp_trap))
    else begin
        errors++;
        $display("ERR trap_flg got %h expected %h", $sampled(trap_flg),
                 $sampled(csr_valid && exp_trap));
    end

    vector_check: assert property (@(posedge clk) disable iff (!rst_n)
        trap_q |-> (trap_vector == vec_q))
    else begin
        errors++;
        $display("ERR trap_vector got %h expected %h", $sampled(trap_vector), $sampled(vec_q));
    end

    // CSR value as the reference model sees it
    function automatic logic [31:0] model_value(input logic [11:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            csr_pkg::ADDR_MSTATUS: begin
                v[csr_pkg::MSTATUS_MIE_BIT]      = m_mie;
                v[csr_pkg::MSTATUS_MPIE_BIT]     = m_mpie;
                v[csr_pkg::MSTATUS_MPP_LSB +: 2] = m_mpp;
            end
            csr_pkg::ADDR_MISA:     v = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MIE:      v[csr_pkg::MTIP_MTIE_BIT] = m_mtie;
            csr_pkg::ADDR_MTVEC:    v = m_mtvec;
            csr_pkg::ADDR_MSCRATCH: v = m_mscratch;
            csr_pkg::ADDR_MEPC:     v = m_mepc;
            csr_pkg::ADDR_MCAUSE:   v = m_mcause;
            csr_pkg::ADDR_MIP:      v[csr_pkg::MTIP_MTIE_BIT] = m_mtip;
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:    v = cycle_count[31:0];
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH:   v = cycle_count[63:32];
            csr_pkg::ADDR_TIME:     v = mtime[31:0];
            csr_pkg::ADDR_TIMEH:    v = mtime[63:32];
            default:                v = '0;
        endcase
        return v;
    endfunction

    // One valid cycle, with the model stepped and expectations launched
    task automatic issue(input csr_pkg::csr_cmd_e cmd, input logic [11:0] addr,
                         input logic [31:0] op1, input logic [31:0] pc,
                         input logic mem_write);
        csr_pkg::csr_req_t r;
        logic [31:0]       cur;
        logic [31:0]       nv;
        logic              acc;
        logic              irq;
        logic              ecall;
        logic              mret;
        @(posedge clk);
        acc   = addr[9:8] <= m_mode;
        cur   = model_value(addr);
        irq   = !mem_write && m_mtip && m_mie && m_mtie;
        ecall = !irq && (cmd == csr_pkg::CSR_ECALL);
        mret  = !irq && !ecall && (cmd == csr_pkg::CSR_MRET);
        exp_rdata <= acc ? cur : 32'd0;
        exp_trap  <= irq || ecall || mret;
        if (irq) begin
            exp_vec <= {m_mtvec[31:2], 2'b00} + ((m_mtvec[1:0] == 2'b01) ? 32'd28 : 32'd0);
        end else if (ecall) begin
            exp_vec <= {m_mtvec[31:2], 2'b00};
        end else begin
            exp_vec <= m_mepc;
        end
        if (!irq) begin
            m_mtip = mtime >= mtimecmp;
        end
        if (irq || ecall) begin
            if (irq) begin
                m_mcause = csr_pkg::CAUSE_M_TIMER_IRQ;
            end else if (m_mode == 2'b00) begin
                m_mcause = csr_pkg::CAUSE_ECALL_U;
            end else begin
                m_mcause = csr_pkg::CAUSE_ECALL_M;
            end
            m_mepc = pc;
            m_mpp  = m_mode;
            m_mpie = m_mie;
            m_mie  = 1'b0;
            m_mode = 2'b11;
        end else if (mret) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_mode = (m_mpp == 2'b11) ? 2'b11 : 2'b00;
            m_mpp  = 2'b00;
        end else if ((cmd == csr_pkg::CSR_W || cmd == csr_pkg::CSR_S ||
                      cmd == csr_pkg::CSR_C) && acc && !(&addr[11:10])) begin
            if (cmd == csr_pkg::CSR_W) begin
                nv = op1;
            end else if (cmd == csr_pkg::CSR_S) begin
                nv = cur | op1;
            end else begin
                nv = cur & ~op1;
            end
            case (addr)
                csr_pkg::ADDR_MSTATUS: begin
                    m_mie  = nv[csr_pkg::MSTATUS_MIE_BIT];
                    m_mpie = nv[csr_pkg::MSTATUS_MPIE_BIT];
                    m_mpp  = nv[csr_pkg::MSTATUS_MPP_LSB +: 2];
                end
                csr_pkg::ADDR_MIE:      m_mtie     = nv[csr_pkg::MTIP_MTIE_BIT];
                csr_pkg::ADDR_MTVEC:    m_mtvec    = nv;
                csr_pkg::ADDR_MSCRATCH: m_mscratch = nv;
                csr_pkg::ADDR_MEPC:     m_mepc     = {nv[31:2], 2'b00};
                csr_pkg::ADDR_MCAUSE:   m_mcause   = nv;
                default: ;
            endcase
        end
        r.pc        = pc;
        r.cmd       = cmd;
        r.op1       = op1;
        r.addr      = addr;
        r.mem_write = mem_write;
        req       <= r;
        csr_valid <= 1'b1;
        n_instr++;
    endtask

    task automatic go_idle();
        @(posedge clk);
        csr_valid <= 1'b0;
        exp_trap  <= 1'b0;
    endtask

    // Write, set, clear, then a plain read
    task automatic exercise_rw(input logic [11:0] addr);
        issue(csr_pkg::CSR_W, addr, $random(seed), 32'h0, 1'b0);
        issue(csr_pkg::CSR_S, addr, $random(seed), 32'h0, 1'b0);
        issue(csr_pkg::CSR_C, addr, $random(seed), 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, addr, 32'h0, 32'h0, 1'b0);
    endtask

    // Hang guard for the whole run
    initial begin
        repeat (2000) @(posedge clk);
        $display("Simulation timed out before the test sequence finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed = 32'h265b_e564;
        errors = 0;
        n_instr = 0;
        rst_n = 1'b0;
        csr_valid = 1'b0;
        req = '0;
        cycle_count = '0;
        mtime = '0;
        mtimecmp = '1;
        exp_rdata = '0;
        exp_trap = 1'b0;
        exp_vec = '0;
        valid_q = 1'b0;
        rdata_q = '0;
        trap_q = 1'b0;
        vec_q = '0;
        // Reset state, Machine mode with MPP Machine
        m_mode = 2'b11;
        m_mpp = 2'b11;
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_mtie = 1'b0;
        m_mtip = 1'b0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        exercise_rw(csr_pkg::ADDR_MSCRATCH);
        exercise_rw(csr_pkg::ADDR_MTVEC);

        // Counter views and misa
        @(posedge clk);
        cycle_count <= {$random(seed), $random(seed)};
        mtime       <= {$random(seed), $random(seed)};
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_CYCLE, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_CYCLEH, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_TIME, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_TIMEH, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MCYCLEH, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MISA, 32'h0, 32'h0, 1'b0);
        // Read-only counter keeps its value
        issue(csr_pkg::CSR_W, csr_pkg::ADDR_CYCLE, $random(seed), 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_CYCLE, 32'h0, 32'h0, 1'b0);

        // ECALL from Machine mode
        issue(csr_pkg::CSR_ECALL, 12'h000, 32'h0, 32'h0000_0124, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MCAUSE, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MEPC, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MSTATUS, 32'h0, 32'h0, 1'b0);

        // MPP to User, then MRET into User mode
        issue(csr_pkg::CSR_C, csr_pkg::ADDR_MSTATUS, 32'h0000_1800, 32'h0, 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::ADDR_MEPC, $random(seed), 32'h0, 1'b0);
        issue(csr_pkg::CSR_MRET, 12'h000, 32'h0, 32'h0000_0200, 1'b0);
        // Machine CSR hidden in User mode
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MSCRATCH, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::ADDR_MSCRATCH, $random(seed), 32'h0, 1'b0);
        issue(csr_pkg::CSR_ECALL, 12'h000, 32'h0, 32'h0000_0300, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MCAUSE, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MSCRATCH, 32'h0, 32'h0, 1'b0);

        // Timer interrupt, vectored mtvec
        issue(csr_pkg::CSR_W, csr_pkg::ADDR_MTVEC, 32'h0000_4001, 32'h0, 1'b0);
        issue(csr_pkg::CSR_S, csr_pkg::ADDR_MIE, 32'h0000_0080, 32'h0, 1'b0);
        issue(csr_pkg::CSR_S, csr_pkg::ADDR_MSTATUS, 32'h0000_0008, 32'h0, 1'b0);
        go_idle();
        mtimecmp <= mtime - 64'd5;
        // Memory writes never trap, poll mip until MTIP shows
        tries = 0;
        do begin
            issue(csr_pkg::CSR_X, csr_pkg::ADDR_MIP, 32'h0, 32'h0000_0400, 1'b1);
            go_idle();
            @(negedge clk);
            tries++;
        end while (!rdata[csr_pkg::MTIP_MTIE_BIT] && tries < 20);
        if (!rdata[csr_pkg::MTIP_MTIE_BIT]) begin
            errors++;
            $display("MTIP never became visible in mip");
        end
        // Interrupted write to mscratch is dropped
        issue(csr_pkg::CSR_W, csr_pkg::ADDR_MSCRATCH, $random(seed), 32'h0000_0500, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MCAUSE, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MSTATUS, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MEPC, 32'h0, 32'h0, 1'b0);
        issue(csr_pkg::CSR_X, csr_pkg::ADDR_MSCRATCH, 32'h0, 32'h0, 1'b0);
        go_idle();
        repeat (3) @(posedge clk);

        $display("instructions=%0d errors=%0d", n_instr, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: cpu_csr.f
source/csr_pkg.sv
source/csr_access_decode.sv
source/csr_machine_regs.sv
source/csr_trap_ctrl.sv
source/cpu_csr.sv
verification/cpu_csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert \
    --top-module cpu_csr_tb -f cpu_csr.f -o cpu_csr_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpu_csr_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the outcome
if grep -q "RESULT: FAIL" "$log"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
